// ==== build.f ====
+incdir+design
design/alarmDisplayPkg.sv
design/portRegs.sv
design/ps2Receiver.sv
design/vgaTiming.sv
design/vgaPainter.sv
design/alarmTone.sv
design/alarmDisplayTop.sv
tb/alarmDisplay_sva.sv
tb/alarmDisplayTb.sv

// ==== run.sh ====
#!/bin/sh
# Compiles and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module alarmDisplayTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "TESTS PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb/alarmDisplayTb.sv ====
// Pixel checks run only while the display setup is held still and bus reads sample one edge late
`timescale 1ns/1ps
`include "alarmDisplay_settings.svh"

module alarmDisplayTb;

	localparam int frameCycles = `H_TOTAL * `V_TOTAL;
	localparam int numWrites = 200;
	localparam int numGood = 12;
	localparam int numBad = 6;
	localparam int framesSimulated = 4; // Two plain and two with alarm
	localparam int ps2Cycles = 600; // One PS/2 frame plus its checks
	localparam int limitNs = 4 * ((framesSimulated + 2) * frameCycles
		+ (numGood + numBad) * ps2Cycles + numWrites * 10);

	logic CLK = 1'b0;
	logic arstN;
	logic [7:0] POR_ID;
	logic [7:0] OUT_PORT;
	logic WRITE_STROBE;
	logic ALARMA;
	logic ps2c;
	logic DATA_IN;
	logic SOLICITUD;
	alarmDisplayPkg::rgb_t RGB;
	logic HS;
	logic VS;
	logic [7:0] DATA_OUT_TEC;
	logic speaker;

	integer seed = 32'hde715807;
	int errCount = 0;
	logic [7:0] mFgLo, mBgLo, mBar, mCode, mPrev; // Model registers
	logic [3:0] mFgHi, mBgHi;
	logic mValid;
	int mx, my, mframe; // Model beam at the pins
	int cycle, lastHsFall, lastVsFall;
	int toneCnt, toggles;
	logic mSpk, hsPrev, vsPrev, spkPrev;
	logic rgbCheckOn;

	alarmDisplayTop dut0 (.*);

	always #2 CLK = ~CLK; // 4 ns period

	initial begin
		#(limitNs);
		$display("Watchdog timeout after %0d ns with the run still going", limitNs);
		$display("TESTS FAILED");
		$fatal(1, "Watchdog expired");
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			errCount++;
			$display("ERROR at %0t ns: %s expected %0h got %0h", $time, name, expected, got);
			$display("TESTS FAILED");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	////////////////////////////////////////
	// Reference model
	function automatic logic [7:0] modelRead(input logic [7:0] id);
		case (id)
			`PORT_FG_LO: return mFgLo;
			`PORT_FG_HI: return {4'h0, mFgHi}; // Zero upper nibble
			`PORT_BG_LO: return mBgLo;
			`PORT_BG_HI: return {4'h0, mBgHi};
			`PORT_BAR: return mBar;
			`PORT_KBD_CODE: return mCode;
			`PORT_KBD_PREV: return mPrev;
			`PORT_KBD_STATUS: return {7'h00, mValid};
			default: return 8'h00;
		endcase
	endfunction

	function automatic alarmDisplayPkg::rgb_t expectedPixel();
		alarmDisplayPkg::rgb_t fg;
		alarmDisplayPkg::rgb_t bg;
		fg = {mFgHi, mFgLo};
		bg = {mBgHi, mBgLo};
		if (ALARMA && mframe[0]) begin
			fg = {mBgHi, mBgLo}; // Flash on odd frames
			bg = {mFgHi, mFgLo};
		end
		if (mx >= `H_ACTIVE || my >= `V_ACTIVE)
			return '0;
		return (mx < mBar * 8) ? fg : bg;
	endfunction

	// Beam and tone model sampled on falling edges
	always @(negedge CLK) begin
		if (!arstN) begin
			mx = `H_TOTAL - 1; // One step before the top-left pixel
			my = `V_TOTAL - 1;
			mframe = -1;
			cycle = 0;
			lastHsFall = -1;
			lastVsFall = -1;
			toneCnt = 0;
			toggles = 0;
			mSpk = 1'b0;
			hsPrev = 1'b1;
			vsPrev = 1'b1;
			spkPrev = 1'b0;
		end else begin
			cycle++;
			mx++;
			if (mx == `H_TOTAL) begin
				mx = 0;
				my++;
				if (my == `V_TOTAL) begin
					my = 0;
					mframe++;
				end
			end
			if (hsPrev && !HS) begin
				checkValue("x at HS fall", mx, `H_SYNC_START);
				mx = `H_SYNC_START; // Resync
				if (lastHsFall >= 0)
					checkValue("HS period", cycle - lastHsFall, `H_TOTAL);
				lastHsFall = cycle;
			end
			if (vsPrev && !VS) begin
				if (lastVsFall >= 0)
					checkValue("VS period", cycle - lastVsFall, frameCycles);
				lastVsFall = cycle;
			end
			checkValue("HS", HS, !(mx >= `H_SYNC_START && mx < `H_SYNC_END));
			checkValue("VS", VS, !(my >= `V_SYNC_START && my < `V_SYNC_END));
			if (rgbCheckOn)
				checkValue("RGB", RGB, expectedPixel());
			if (ALARMA) begin
				toneCnt++;
				if (toneCnt == `TONE_HALF) begin
					toneCnt = 0;
					mSpk = !mSpk;
				end
			end else begin
				toneCnt = 0;
				mSpk = 1'b0;
			end
			checkValue("speaker", speaker, mSpk);
			if (speaker !== spkPrev)
				toggles++; // Edges seen at the pin
			spkPrev = speaker;
			hsPrev = HS;
			vsPrev = VS;
		end
	end

	////////////////////////////////////////
	// Bus and keyboard stimulus
	function automatic logic [7:0] pickPort(input logic [31:0] r);
		logic [7:0] mapped [8] = '{`PORT_FG_LO, `PORT_FG_HI, `PORT_BG_LO, `PORT_BG_HI,
			`PORT_BAR, `PORT_KBD_CODE, `PORT_KBD_PREV, `PORT_KBD_STATUS};
		return r[4] ? r[31:24] : mapped[r[2:0]]; // Any id or a mapped one
	endfunction

	task automatic writePort(input logic [7:0] id, input logic [7:0] data);
		POR_ID <= id;
		OUT_PORT <= data;
		WRITE_STROBE <= 1'b1;
		@(negedge CLK);
		WRITE_STROBE <= 1'b0;
		case (id)
			`PORT_FG_LO: mFgLo = data;
			`PORT_FG_HI: mFgHi = data[3:0];
			`PORT_BG_LO: mBgLo = data;
			`PORT_BG_HI: mBgHi = data[3:0];
			`PORT_BAR: mBar = data;
			default: ;
		endcase
	endtask

	task automatic checkRead(input logic [7:0] id);
		POR_ID <= id;
		@(negedge CLK);
		checkValue($sformatf("DATA_OUT_TEC at port %02h", id), DATA_OUT_TEC, modelRead(id));
	endtask

	task automatic checkKbd();
		checkRead(`PORT_KBD_CODE);
		checkRead(`PORT_KBD_PREV);
		checkRead(`PORT_KBD_STATUS);
	endtask

	task automatic acknowledge();
		POR_ID <= `PORT_KBD_CODE;
		SOLICITUD <= 1'b1;
		@(negedge CLK);
		SOLICITUD <= 1'b0;
		mValid = 1'b0;
	endtask

	task automatic sendFrame(input logic [7:0] code, input logic badParity, input logic badStop);
		logic [10:0] bits;
		bits = {!badStop, (~^code) ^ badParity, code, 1'b0}; // Stop parity data start
		POR_ID <= `PORT_KBD_CODE;
		for (int i = 0; i <= 10; i++) begin
			DATA_IN <= bits[i];
			repeat (20) @(negedge CLK);
			ps2c <= 1'b0;
			if (i < 10) begin
				repeat (20) @(negedge CLK);
				ps2c <= 1'b1;
			end
		end
		repeat (4) @(negedge CLK); // Code due within 4 cycles of stop edge
		if (!badParity && !badStop) begin
			mPrev = mCode;
			mCode = code;
			mValid = 1'b1;
		end
		checkValue("DATA_OUT_TEC code after stop bit", DATA_OUT_TEC, mCode);
		repeat (16) @(negedge CLK);
		ps2c <= 1'b1;
		DATA_IN <= 1'b1;
		repeat (20) @(negedge CLK);
	endtask

	task automatic randomCfg();
		writePort(`PORT_FG_LO, 8'($random(seed)));
		writePort(`PORT_FG_HI, 8'($random(seed)));
		writePort(`PORT_BG_LO, 8'($random(seed)));
		writePort(`PORT_BG_HI, 8'($random(seed)));
		writePort(`PORT_BAR, 8'($random(seed) & 127)); // Bar mostly on screen
		repeat (4) @(negedge CLK);
	endtask

	////////////////////////////////////////
	initial begin
		logic [7:0] id;
		arstN = 1'b0;
		POR_ID = 8'h00;
		OUT_PORT = 8'h00;
		WRITE_STROBE = 1'b0;
		SOLICITUD = 1'b0;
		ALARMA = 1'b0;
		ps2c = 1'b1; // PS/2 idle high
		DATA_IN = 1'b1;
		rgbCheckOn = 1'b0;
		{mFgLo, mFgHi, mBgLo, mBgHi, mBar, mCode, mPrev, mValid} = '0;
		repeat (10) @(negedge CLK);
		checkValue("HS in reset", HS, 1'b1);
		checkValue("VS in reset", VS, 1'b1);
		checkValue("RGB in reset", RGB, 12'h000);
		arstN <= 1'b1;
		@(negedge CLK);

		for (int i = 0; i < numWrites; i++) begin
			id = pickPort($random(seed));
			writePort(id, 8'($random(seed)));
			checkRead(id);
			checkRead(pickPort($random(seed)));
		end

		for (int i = 0; i < numGood; i++) begin
			sendFrame(8'($random(seed)), 1'b0, 1'b0);
			checkKbd();
			if (i % 3 == 2) begin
				acknowledge(); // Next two frames arrive unread
				checkKbd();
			end
		end
		for (int i = 0; i < numBad; i++) begin
			sendFrame(8'($random(seed)), i[0], !i[0]);
			checkKbd();
		end

		randomCfg();
		rgbCheckOn <= 1'b1;
		repeat (2 * frameCycles) @(negedge CLK);
		rgbCheckOn <= 1'b0;

		ALARMA <= 1'b1;
		randomCfg();
		rgbCheckOn <= 1'b1;
		repeat (2 * frameCycles) @(negedge CLK);
		rgbCheckOn <= 1'b0;
		checkValue("speaker toggles seen", toggles >= 2 * frameCycles / `TONE_HALF, 1'b1);
		ALARMA <= 1'b0;
		repeat (3) @(negedge CLK);
		checkValue("speaker after alarm", speaker, 1'b0);

		if (errCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== tb/alarmDisplay_sva.sv ====
// Pin-level checks on the top level only and the HS width is counted from sampled values
`timescale 1ns/1ps
`include "alarmDisplay_settings.svh"

module alarmDisplayChecks (
	input logic CLK,
	input logic arstN,
	input logic HS,
	input logic ALARMA,
	input logic speaker,
	input logic [7:0] POR_ID,
	input logic [7:0] DATA_OUT_TEC
);

	logic [9:0] hsLow; // Low cycles of the current pulse
	logic mapped;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			hsLow <= '0;
		else if (!HS)
			hsLow <= hsLow + 10'd1;
		else
			hsLow <= '0; // Pulse over
	end

	assign mapped = POR_ID inside {`PORT_FG_LO, `PORT_FG_HI, `PORT_BG_LO, `PORT_BG_HI,
		`PORT_BAR, `PORT_KBD_CODE, `PORT_KBD_PREV, `PORT_KBD_STATUS};

	////////////////////////////////////////
	hsWidth: assert property (@(posedge CLK) disable iff (!arstN)
		$rose(HS) |-> hsLow == 10'(`H_SYNC))
		else $error("HS low pulse did not last %0d cycles", `H_SYNC);

	// Tone is cleared one edge after the alarm drops
	speakerQuiet: assert property (@(posedge CLK) disable iff (!arstN) !ALARMA |=> !speaker)
		else $error("speaker high while ALARMA low");

	unmappedZero: assert property (@(posedge CLK) disable iff (!arstN)
		!mapped |-> DATA_OUT_TEC == 8'h00)
		else $error("DATA_OUT_TEC not zero for unmapped port id");

endmodule

bind alarmDisplayTop alarmDisplayChecks sva0 (
	.CLK(CLK),
	.arstN(arstN),
	.HS(HS),
	.ALARMA(ALARMA),
	.speaker(speaker),
	.POR_ID(POR_ID),
	.DATA_OUT_TEC(DATA_OUT_TEC)
);

// ==== design/alarmDisplayTop.sv ====
// Single clock domain at the pixel rate, PS/2 lines are asynchronous and synchronized inside
`timescale 1ns/1ps

module alarmDisplayTop (
	input logic CLK,
	input logic arstN,
	input logic [7:0] POR_ID,
	input logic [7:0] OUT_PORT,
	input logic WRITE_STROBE,
	input logic ALARMA,
	input logic ps2c,
	input logic DATA_IN,
	input logic SOLICITUD,
	output alarmDisplayPkg::rgb_t RGB,
	output logic HS,
	output logic VS,
	output logic [7:0] DATA_OUT_TEC,
	output logic speaker
);

	alarmDisplayPkg::displayCfg_t cfg; // Registers to painter
	alarmDisplayPkg::kbdCodes_t kbd; // Keyboard to registers
	alarmDisplayPkg::vgaBeam_t beam; // Timing to painter
	logic kbdAck;

	////////////////////////////////////////
	// Processor side
	portRegs regs0 (
		.CLK(CLK),
		.arstN(arstN),
		.POR_ID(POR_ID),
		.OUT_PORT(OUT_PORT),
		.WRITE_STROBE(WRITE_STROBE),
		.SOLICITUD(SOLICITUD),
		.kbd(kbd),
		.cfg(cfg),
		.DATA_OUT_TEC(DATA_OUT_TEC),
		.kbdAck(kbdAck)
	);

	ps2Receiver kbd0 (
		.CLK(CLK),
		.arstN(arstN),
		.ps2c(ps2c),
		.DATA_IN(DATA_IN),
		.kbdAck(kbdAck),
		.kbd(kbd)
	);

	////////////////////////////////////////
	// Display and sound
	vgaTiming timing0 (.CLK(CLK), .arstN(arstN), .beam(beam));

	vgaPainter painter0 (
		.CLK(CLK),
		.arstN(arstN),
		.ALARMA(ALARMA),
		.beam(beam),
		.cfg(cfg),
		.RGB(RGB),
		.HS(HS),
		.VS(VS)
	);

	alarmTone tone0 (.CLK(CLK), .arstN(arstN), .ALARMA(ALARMA), .speaker(speaker));

endmodule

// ==== design/alarmTone.sv ====
// Fixed single tone, speaker stays low and the divider cleared whenever ALARMA is low
`timescale 1ns/1ps
`include "alarmDisplay_settings.svh"

module alarmTone (
	input logic CLK,
	input logic arstN,
	input logic ALARMA,
	output logic speaker
);

	localparam logic [`TONE_BITS-1:0] lastCount = `TONE_BITS'(`TONE_HALF - 1);

	logic [`TONE_BITS-1:0] divCnt;

	// Divider runs only with the alarm on
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			divCnt <= '0;
			speaker <= 1'b0;
		end else if (!ALARMA) begin
			divCnt <= '0; // Restart tone phase
			speaker <= 1'b0;
		end else if (divCnt == lastCount) begin
			divCnt <= '0;
			speaker <= !speaker; // Half period done
		end else begin
			divCnt <= divCnt + 1'b1;
		end
	end

endmodule

// ==== design/vgaPainter.sv ====
// One pipeline stage, so the syncs are delayed here too and must not be taken from vgaTiming
`timescale 1ns/1ps
`include "alarmDisplay_settings.svh"

module vgaPainter (
	input logic CLK,
	input logic arstN,
	input logic ALARMA,
	input alarmDisplayPkg::vgaBeam_t beam,
	input alarmDisplayPkg::displayCfg_t cfg,
	output alarmDisplayPkg::rgb_t RGB,
	output logic HS,
	output logic VS
);

	logic [10:0] barEnd; // First pixel past the bar
	logic inBar;
	logic swap; // Alarm flash phase
	alarmDisplayPkg::rgb_t fgEff;
	alarmDisplayPkg::rgb_t bgEff;
	alarmDisplayPkg::rgb_t pixel;

	////////////////////////////////////////
	// Color choice
	always_comb begin
		barEnd = 11'(cfg.barLevel) << `BAR_SHIFT;
		inBar = ({1'b0, beam.x} < barEnd);
		swap = ALARMA && beam.frameOdd;

		// Swap on odd frames while alarm is on
		if (swap) begin
			fgEff = cfg.bg;
			bgEff = cfg.fg;
		end else begin
			fgEff = cfg.fg;
			bgEff = cfg.bg;
		end

		if (!beam.active)
			pixel = '0; // Blank in porches and sync
		else if (inBar)
			pixel = fgEff;
		else
			pixel = bgEff;
	end

	////////////////////////////////////////
	// Output stage, color and syncs together
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			RGB <= '0;
			HS <= 1'b1;
			VS <= 1'b1;
		end else begin
			RGB <= pixel;
			HS <= beam.hs; // Same delay as color
			VS <= beam.vs;
		end
	end

endmodule

// ==== design/vgaTiming.sv ====
// Pixel clock assumed at 25 MHz, counters and syncs leave reset at the top-left pixel
`timescale 1ns/1ps
`include "alarmDisplay_settings.svh"

module vgaTiming (
	input logic CLK,
	input logic arstN,
	output alarmDisplayPkg::vgaBeam_t beam
);

	logic [9:0] xCnt;
	logic [9:0] yCnt;
	logic [9:0] xNext;
	logic [9:0] yNext;
	logic xWrap; // Last pixel of line
	logic yWrap; // Last line of frame
	logic [`FRAME_BITS-1:0] frameCnt;
	logic hsReg;
	logic vsReg;

	always_comb begin
		xWrap = (xCnt == 10'(`H_TOTAL - 1));
		yWrap = (yCnt == 10'(`V_TOTAL - 1));
		xNext = xWrap ? 10'd0 : xCnt + 10'd1;
		yNext = yCnt;
		if (xWrap)
			yNext = yWrap ? 10'd0 : yCnt + 10'd1;
	end

	// Syncs come from next position so they line up with the counters
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			xCnt <= '0;
			yCnt <= '0;
			frameCnt <= '0;
			hsReg <= 1'b1; // Inactive
			vsReg <= 1'b1;
		end else begin
			xCnt <= xNext;
			yCnt <= yNext;
			if (xWrap && yWrap)
				frameCnt <= frameCnt + 1'b1;
			hsReg <= !(xNext >= 10'(`H_SYNC_START) && xNext < 10'(`H_SYNC_END));
			vsReg <= !(yNext >= 10'(`V_SYNC_START) && yNext < 10'(`V_SYNC_END));
		end
	end

	////////////////////////////////////////
	assign beam.x = xCnt;
	assign beam.y = yCnt;
	assign beam.active = (xCnt < 10'(`H_ACTIVE)) && (yCnt < 10'(`V_ACTIVE));
	assign beam.hs = hsReg;
	assign beam.vs = vsReg;
	assign beam.frameOdd = frameCnt[`FLASH_BIT]; // Flash phase

endmodule

// ==== design/ps2Receiver.sv ====
// Device-to-host frames only, no timeout so a glitch on ps2c leaves the bit counter misaligned
`timescale 1ns/1ps

module ps2Receiver (
	input logic CLK,
	input logic arstN,
	input logic ps2c,
	input logic DATA_IN,
	input logic kbdAck,
	output alarmDisplayPkg::kbdCodes_t kbd
);

	localparam logic [3:0] lastBit = 4'd10; // Start, 8 data, parity, stop

	logic ps2cMeta; // Sync stage 1
	logic ps2cSync; // Sync stage 2
	logic ps2cLast; // Edge detect
	logic dataMeta;
	logic dataSync;
	logic fallEdge;
	logic [3:0] bitCnt;
	logic [9:0] shiftReg; // Bits 0..9 of the frame
	logic [10:0] frame; // Full frame incl. stop bit
	logic frameGood;
	logic frameDone;

	////////////////////////////////////////
	// Input synchronizers
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			ps2cMeta <= 1'b1; // Idle bus is high
			ps2cSync <= 1'b1;
			ps2cLast <= 1'b1;
			dataMeta <= 1'b1;
			dataSync <= 1'b1;
		end else begin
			ps2cMeta <= ps2c;
			ps2cSync <= ps2cMeta;
			ps2cLast <= ps2cSync;
			dataMeta <= DATA_IN;
			dataSync <= dataMeta;
		end
	end

	assign fallEdge = ps2cLast && !ps2cSync;

	////////////////////////////////////////
	// Frame assembly, LSB first
	always_ff @(posedge CLK) begin
		if (fallEdge)
			shiftReg <= {dataSync, shiftReg[9:1]};
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			bitCnt <= '0;
		else if (fallEdge)
			bitCnt <= (bitCnt == lastBit) ? 4'd0 : bitCnt + 4'd1;
	end

	assign frame = {dataSync, shiftReg}; // Stop bit arrives now
	assign frameDone = fallEdge && (bitCnt == lastBit);

	// Start low, stop high, odd parity over data plus parity bit
	assign frameGood = !frame[0] && frame[10] && (^frame[9:1]);

	////////////////////////////////////////
	// Held codes
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			kbd.current <= '0;
			kbd.previous <= '0;
			kbd.valid <= 1'b0;
		end else if (frameDone && frameGood) begin
			kbd.previous <= kbd.current; // Overwrites even if unread
			kbd.current <= frame[8:1];
			kbd.valid <= 1'b1;
		end else if (kbdAck) begin
			kbd.valid <= 1'b0;
		end
	end

endmodule

// ==== design/portRegs.sv ====
// Writes take effect on the strobe edge, reads are combinational from POR_ID with no wait state
`timescale 1ns/1ps
`include "alarmDisplay_settings.svh"

module portRegs (
	input logic CLK,
	input logic arstN,
	input logic [7:0] POR_ID,
	input logic [7:0] OUT_PORT,
	input logic WRITE_STROBE,
	input logic SOLICITUD,
	input alarmDisplayPkg::kbdCodes_t kbd,
	output alarmDisplayPkg::displayCfg_t cfg,
	output logic [7:0] DATA_OUT_TEC,
	output logic kbdAck
);

	logic [7:0] fgLo; // Bar green, blue
	logic [3:0] fgHi; // Bar red
	logic [7:0] bgLo;
	logic [3:0] bgHi;
	logic [7:0] barLen;

	// Write decode
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			fgLo <= '0;
			fgHi <= '0;
			bgLo <= '0;
			bgHi <= '0;
			barLen <= '0;
		end else if (WRITE_STROBE) begin
			case (POR_ID)
				`PORT_FG_LO: fgLo <= OUT_PORT;
				`PORT_FG_HI: fgHi <= OUT_PORT[3:0]; // Upper nibble dropped
				`PORT_BG_LO: bgLo <= OUT_PORT;
				`PORT_BG_HI: bgHi <= OUT_PORT[3:0];
				`PORT_BAR: barLen <= OUT_PORT;
				default: ; // Unmapped id, ignore
			endcase
		end
	end

	// Red nibble on top, then green, blue
	assign cfg.fg = {fgHi, fgLo};
	assign cfg.bg = {bgHi, bgLo};
	assign cfg.barLevel = barLen;

	// Read mux
	always_comb begin
		case (POR_ID)
			`PORT_FG_LO: DATA_OUT_TEC = fgLo;
			`PORT_FG_HI: DATA_OUT_TEC = {4'h0, fgHi};
			`PORT_BG_LO: DATA_OUT_TEC = bgLo;
			`PORT_BG_HI: DATA_OUT_TEC = {4'h0, bgHi};
			`PORT_BAR: DATA_OUT_TEC = barLen;
			`PORT_KBD_CODE: DATA_OUT_TEC = kbd.current;
			`PORT_KBD_PREV: DATA_OUT_TEC = kbd.previous;
			`PORT_KBD_STATUS: DATA_OUT_TEC = {7'h00, kbd.valid};
			default: DATA_OUT_TEC = 8'h00;
		endcase
	end

	assign kbdAck = SOLICITUD && (POR_ID == `PORT_KBD_CODE); // Code read consumes valid

endmodule

// ==== design/alarmDisplayPkg.sv ====
// Shared packed types only, colors are 4 bits per channel with red in the top nibble
package alarmDisplayPkg;

	// One 12-bit pixel color
	typedef struct packed {
		logic [3:0] r; // Red
		logic [3:0] g; // Green
		logic [3:0] b; // Blue
	} rgb_t;

	// Display setup written by the processor
	typedef struct packed {
		rgb_t fg; // Bar color
		rgb_t bg; // Background color
		logic [7:0] barLevel; // Bar length / 8
	} displayCfg_t;

	// Keyboard codes held for readback
	typedef struct packed {
		logic [7:0] current; // Latest scan code
		logic [7:0] previous; // Code before it
		logic valid; // Unread code present
	} kbdCodes_t;

	// Beam position and sync, one pixel per clock
	typedef struct packed {
		logic [9:0] x; // Pixel column
		logic [9:0] y; // Line number
		logic active; // Inside 640x480
		logic hs; // Active low
		logic vs; // Active low
		logic frameOdd; // Flash phase
	} vgaBeam_t;

endpackage

// ==== design/alarmDisplay_settings.svh ====
// Timing fixed for 640x480 at a 25 MHz pixel clock, all ports share one 8-bit port-id space
`ifndef ALARM_DISPLAY_SETTINGS_SVH
`define ALARM_DISPLAY_SETTINGS_SVH

////////////////////////////////////////
// VGA horizontal timing, in pixels
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800
`define H_SYNC_START (`H_ACTIVE + `H_FRONT) // 656
`define H_SYNC_END (`H_SYNC_START + `H_SYNC) // 752

// VGA vertical timing, in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525
`define V_SYNC_START (`V_ACTIVE + `V_FRONT) // 490
`define V_SYNC_END (`V_SYNC_START + `V_SYNC) // 492

////////////////////////////////////////
// Port map seen by the processor
`define PORT_FG_LO 8'h10 // Bar color, green and blue
`define PORT_FG_HI 8'h11 // Bar color, red nibble
`define PORT_BG_LO 8'h12
`define PORT_BG_HI 8'h13
`define PORT_BAR 8'h14 // Bar length, units of 8 px
`define PORT_KBD_CODE 8'h20
`define PORT_KBD_PREV 8'h21
`define PORT_KBD_STATUS 8'h22

////////////////////////////////////////
`define TONE_HALF 28409 // Cycles per speaker half period
`define TONE_BITS 15
`define FLASH_BIT 0 // Frame bit driving the alarm flash
`define FRAME_BITS 4
`define BAR_SHIFT 3 // Bar unit is 2**3 pixels

`endif
